//--- compile.f
+incdir+include
hdl/sample_pkg.sv
hdl/trigger_pkg.sv
hdl/trig_counter.sv
hdl/load_sequencer.sv
hdl/group_mux.sv
hdl/sync_fifo.sv
hdl/readout_merge.sv
hdl/fifo16_wide.sv
tb/fifo16_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fifo16_wide testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module fifo16_tb -Mdir obj_dir \
	&& ./obj_dir/Vfifo16_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

//--- tb/fifo16_tb.sv
`timescale 1ns/1ps
`include "fifo16_cfg.svh"

module fifo16_tb;

	localparam int RST_CYCLES = 16;
	localparam int GRP        = `FIFO16_NUM_GRP;
	localparam int LOAD_LAT   = 4;     // Match edge to first write plus margin
	localparam int READY_MAX  = 8;

	// Resets, read strobes, per-event overhead, bursts, extra pulses
	localparam int TEST_CYCLES = 6 * (RST_CYCLES + 1)
		+ 2 * (13 + 1 + 16 + 70 + 8)
		+ 7 * (LOAD_LAT + 2 + READY_MAX + 2)
		+ GRP * (2 + 1 + 2 + 1 + 8 + 8 + 1)
		+ 2 * 5;

	logic                  WRCLK;
	logic                  RST_RESYNC;
	logic                  l1a;
	logic                  l1a_match;
	sample_pkg::grp_bus_t  g [GRP];
	sample_pkg::smp_cnt_t  samp_max;
	logic                  rd;
	logic                  hdr_rd;
	logic                  rdy;
	sample_pkg::grp_bus_t  dout;
	logic                  dout_valid;
	trigger_pkg::evt_hdr_t hdr;
	logic                  hdr_valid;
	logic                  ovf;

	int seed;
	int checks;
	int errors;

	fifo16_wide i_fifo16_wide (
		.WRCLK        (WRCLK),
		.RST_RESYNC   (RST_RESYNC),
		.l1a_i        (l1a),
		.l1a_match_i  (l1a_match),
		.g_i          (g),
		.samp_max_i   (samp_max),
		.rd_i         (rd),
		.hdr_rd_i     (hdr_rd),
		.rdy_o        (rdy),
		.dout_o       (dout),
		.dout_valid_o (dout_valid),
		.hdr_o        (hdr),
		.hdr_valid_o  (hdr_valid),
		.ovf_o        (ovf)
	);

	initial begin
		WRCLK = 1'b0;
		forever #10 WRCLK = ~WRCLK;   // 50 MHz
	end

	initial begin
		repeat (2 * TEST_CYCLES) @(posedge WRCLK);
		$display("Watchdog expired after %0d cycles", 2 * TEST_CYCLES);
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and check helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_int(input string name, input int exp, input int act);
		checks++;
		assert (exp == act) else begin
			$display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bus(input string name, input sample_pkg::grp_bus_t exp,
	                         input sample_pkg::grp_bus_t act);
		checks++;
		assert (exp == act) else begin
			$display("Mismatch in %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err0);
		$display("%s finished with %0d errors", name, errors - err0);
	endtask

	task automatic reset_dut();
		@(negedge WRCLK);
		RST_RESYNC = 1'b1;
		repeat (RST_CYCLES) @(negedge WRCLK);
		RST_RESYNC = 1'b0;
	endtask

	task automatic pulse_l1a();
		@(negedge WRCLK);
		l1a = 1'b1;
		@(negedge WRCLK);
		l1a = 1'b0;
	endtask

	task automatic pulse_match();
		@(negedge WRCLK);
		l1a_match = 1'b1;
		@(negedge WRCLK);
		l1a_match = 1'b0;
	endtask

	task automatic randomize_groups();
		for (int gi = 0; gi < GRP; gi++) begin
			for (int ch = 0; ch < `FIFO16_NUM_CH; ch++) begin
				g[gi][ch] = sample_pkg::smp_word_t'($random(seed));
			end
		end
	endtask

	task automatic wait_rdy(input string name);
		int n;
		n = 0;
		while (!rdy && n < READY_MAX) begin
			@(negedge WRCLK);
			n++;
		end
		checks++;
		assert (rdy) else begin
			$display("%s: no event header became ready after the match", name);
			errors++;
		end
	endtask

	// Burst of 6*(SAMP_MAX+1) writes follows the header
	task automatic load_event(input int smp, input string name);
		samp_max = sample_pkg::smp_cnt_t'(smp);
		pulse_match();
		wait_rdy(name);
		repeat (GRP * (smp + 1) + LOAD_LAT) @(negedge WRCLK);
	endtask

	task automatic read_data(output logic valid, output sample_pkg::grp_bus_t data);
		@(negedge WRCLK);
		rd = 1'b1;
		@(negedge WRCLK);
		rd    = 1'b0;
		valid = dout_valid;
		data  = dout;
	endtask

	task automatic read_header(output logic valid, output trigger_pkg::evt_hdr_t h);
		@(negedge WRCLK);
		hdr_rd = 1'b1;
		@(negedge WRCLK);
		hdr_rd = 1'b0;
		valid  = hdr_valid;
		h      = hdr;
	endtask

	task automatic drain_count(input int max_reads, output int n_valid);
		logic                 valid;
		sample_pkg::grp_bus_t data;
		n_valid = 0;
		for (int k = 0; k < max_reads; k++) begin
			read_data(valid, data);
			if (valid) begin
				n_valid++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_after_reset();
		int err0;
		err0 = errors;
		reset_dut();
		check_int("after_reset rdy", 0, int'(rdy));
		check_int("after_reset dout_valid", 0, int'(dout_valid));
		check_int("after_reset hdr_valid", 0, int'(hdr_valid));
		check_int("after_reset ovf", 0, int'(ovf));
		report_test("after_reset", err0);
	endtask

	task automatic test_data_order();
		int                   err0;
		logic                 valid;
		sample_pkg::grp_bus_t data;
		err0 = errors;
		reset_dut();
		randomize_groups();
		load_event(1, "data_order");
		for (int k = 0; k < 2 * GRP; k++) begin
			read_data(valid, data);
			check_int("data_order valid", 1, int'(valid));
			check_bus("data_order word", g[k % GRP], data);
		end
		read_data(valid, data);
		check_int("data_order empty", 0, int'(valid));
		report_test("data_order", err0);
	endtask

	task automatic test_header_counts();
		int                    err0;
		logic                  valid;
		trigger_pkg::evt_hdr_t h;
		err0 = errors;
		reset_dut();
		repeat (3) pulse_l1a();
		load_event(0, "header_counts");
		read_header(valid, h);
		check_int("header_counts valid", 1, int'(valid));
		check_int("header_counts l1a", 3, int'(h.l1a_cnt));
		check_int("header_counts match", 1, int'(h.mtch_cnt));
		check_int("header_counts rdy", 0, int'(rdy));
		report_test("header_counts", err0);
	endtask

	task automatic test_match_while_loading();
		int                    err0;
		int                    n;
		logic                  valid;
		trigger_pkg::evt_hdr_t h;
		err0 = errors;
		reset_dut();
		randomize_groups();
		samp_max = sample_pkg::smp_cnt_t'(1);
		pulse_match();
		repeat (2) @(negedge WRCLK);
		pulse_match();                   // Lands inside the burst
		wait_rdy("match_while_loading");
		repeat (GRP * 2 + LOAD_LAT) @(negedge WRCLK);
		read_header(valid, h);
		check_int("match_while_loading valid", 1, int'(valid));
		check_int("match_while_loading match", 1, int'(h.mtch_cnt));
		check_int("match_while_loading one header", 0, int'(rdy));
		drain_count(2 * GRP + 2, n);
		check_int("match_while_loading words", 2 * GRP, n);
		// Next event shows whether the second match was counted
		load_event(0, "match_while_loading");
		read_header(valid, h);
		check_int("match_while_loading count", 3, int'(h.mtch_cnt));
		report_test("match_while_loading", err0);
	endtask

	task automatic test_overflow();
		int err0;
		int n;
		err0 = errors;
		reset_dut();
		randomize_groups();
		load_event(7, "overflow");
		load_event(7, "overflow");
		check_int("overflow flag", 1, int'(ovf));
		drain_count(`FIFO16_CH_DEPTH + 6, n);
		check_int("overflow words", `FIFO16_CH_DEPTH, n);
		check_int("overflow sticky", 1, int'(ovf));
		report_test("overflow", err0);
	endtask

	task automatic test_sample_count();
		int err0;
		int n;
		err0 = errors;
		reset_dut();
		randomize_groups();
		load_event(0, "sample_count");
		drain_count(GRP + 2, n);
		check_int("sample_count words", GRP, n);
		report_test("sample_count", err0);
	endtask

	initial begin
		seed       = 32'ha54896ca;
		checks     = 0;
		errors     = 0;
		RST_RESYNC = 1'b1;
		l1a        = 1'b0;
		l1a_match  = 1'b0;
		samp_max   = '0;
		rd         = 1'b0;
		hdr_rd     = 1'b0;
		for (int gi = 0; gi < GRP; gi++) begin
			g[gi] = '0;
		end

		test_after_reset();
		test_data_order();
		test_header_counts();
		test_match_while_loading();
		test_overflow();
		test_sample_count();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- hdl/fifo16_wide.sv
`timescale 1ns/1ps
`include "fifo16_cfg.svh"

module fifo16_wide (
	input  logic                  WRCLK,
	input  logic                  RST_RESYNC,
	input  logic                  l1a_i,
	input  logic                  l1a_match_i,
	input  sample_pkg::grp_bus_t  g_i [`FIFO16_NUM_GRP],
	input  sample_pkg::smp_cnt_t  samp_max_i,
	input  logic                  rd_i,
	input  logic                  hdr_rd_i,
	output logic                  rdy_o,
	output sample_pkg::grp_bus_t  dout_o,
	output logic                  dout_valid_o,
	output trigger_pkg::evt_hdr_t hdr_o,
	output logic                  hdr_valid_o,
	output logic                  ovf_o
);

	logic                      evt_start;
	trigger_pkg::evt_hdr_t     start_hdr;
	logic                      busy;
	sample_pkg::grp_sel_t      grp_sel;
	logic                      wr;
	sample_pkg::grp_bus_t      ch_data;
	logic                      ch_wr;
	sample_pkg::grp_bus_t      ch_dout;
	logic [`FIFO16_NUM_CH-1:0] ch_empty;
	logic [`FIFO16_NUM_CH-1:0] ch_rd;
	logic [`FIFO16_NUM_CH-1:0] ch_ovf;
	logic                      hdr_empty;
	logic                      hdr_ovf;

	////////////////////////////////////////////////////////////////////////////
	// Trigger side and load control
	////////////////////////////////////////////////////////////////////////////

	trig_counter i_trig_counter (
		.WRCLK       (WRCLK),
		.RST_RESYNC  (RST_RESYNC),
		.l1a_i       (l1a_i),
		.l1a_match_i (l1a_match_i),
		.busy_i      (busy),
		.evt_start_o (evt_start),
		.hdr_o       (start_hdr)
	);

	load_sequencer i_load_sequencer (
		.WRCLK       (WRCLK),
		.RST_RESYNC  (RST_RESYNC),
		.evt_start_i (evt_start),
		.samp_max_i  (samp_max_i),
		.grp_sel_o   (grp_sel),
		.wr_o        (wr),
		.busy_o      (busy)
	);

	group_mux i_group_mux (
		.WRCLK      (WRCLK),
		.RST_RESYNC (RST_RESYNC),
		.grp_i      (g_i),
		.grp_sel_i  (grp_sel),
		.wr_i       (wr),
		.ch_data_o  (ch_data),
		.ch_wr_o    (ch_wr)
	);

	////////////////////////////////////////////////////////////////////////////
	// Channel buffers fed by one common strobe
	////////////////////////////////////////////////////////////////////////////

	for (genvar ch = 0; ch < `FIFO16_NUM_CH; ch++) begin : g_ch
		sync_fifo #(
			.PAYLOAD_T (sample_pkg::smp_word_t),
			.DEPTH     (`FIFO16_CH_DEPTH)
		) i_ch_fifo (
			.WRCLK      (WRCLK),
			.RST_RESYNC (RST_RESYNC),
			.wr_i       (ch_wr),
			.din_i      (ch_data[ch]),
			.rd_i       (ch_rd[ch]),
			.dout_o     (ch_dout[ch]),
			.empty_o    (ch_empty[ch]),
			.ovf_o      (ch_ovf[ch])
		);
	end

	readout_merge i_readout_merge (
		.WRCLK        (WRCLK),
		.RST_RESYNC   (RST_RESYNC),
		.rd_i         (rd_i),
		.ch_empty_i   (ch_empty),
		.ch_dout_i    (ch_dout),
		.ch_rd_o      (ch_rd),
		.dout_o       (dout_o),
		.dout_valid_o (dout_valid_o)
	);

	// One header per started event
	sync_fifo #(
		.PAYLOAD_T (trigger_pkg::evt_hdr_t),
		.DEPTH     (`FIFO16_HDR_DEPTH)
	) i_hdr_fifo (
		.WRCLK      (WRCLK),
		.RST_RESYNC (RST_RESYNC),
		.wr_i       (evt_start),
		.din_i      (start_hdr),
		.rd_i       (hdr_rd_i),
		.dout_o     (hdr_o),
		.empty_o    (hdr_empty),
		.ovf_o      (hdr_ovf)
	);

	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			hdr_valid_o <= 1'b0;
		end else begin
			hdr_valid_o <= hdr_rd_i & ~hdr_empty;
		end
	end

	assign rdy_o = ~hdr_empty;               // An event waits for readout
	assign ovf_o = (|ch_ovf) | hdr_ovf;      // Each flag is sticky

endmodule

//--- hdl/readout_merge.sv
`timescale 1ns/1ps
`include "fifo16_cfg.svh"

module readout_merge (
	input  logic                      WRCLK,
	input  logic                      RST_RESYNC,
	input  logic                      rd_i,
	input  logic [`FIFO16_NUM_CH-1:0] ch_empty_i,
	input  sample_pkg::grp_bus_t      ch_dout_i,
	output logic [`FIFO16_NUM_CH-1:0] ch_rd_o,
	output sample_pkg::grp_bus_t      dout_o,
	output logic                      dout_valid_o
);

	logic rd_ok;

	// All channels pop together or not at all
	assign rd_ok   = rd_i & ~(|ch_empty_i);
	assign ch_rd_o = {`FIFO16_NUM_CH{rd_ok}};

	// Merged word comes straight from the FIFO output registers
	assign dout_o = ch_dout_i;

	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			dout_valid_o <= 1'b0;
		end else begin
			dout_valid_o <= rd_ok;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Channels are written in lockstep, so their fill levels never part
	////////////////////////////////////////////////////////////////////////////

	a_ch_in_step: assert property (
		@(posedge WRCLK) disable iff (RST_RESYNC)
		(&ch_empty_i) || !(|ch_empty_i)
	) else $error("channel FIFOs out of step");

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter type PAYLOAD_T = logic [7:0],
	parameter int  DEPTH     = 16
) (
	input  logic     WRCLK,
	input  logic     RST_RESYNC,
	input  logic     wr_i,
	input  PAYLOAD_T din_i,
	input  logic     rd_i,
	output PAYLOAD_T dout_o,
	output logic     empty_o,
	output logic     ovf_o
);

	localparam int AW = $clog2(DEPTH);

	PAYLOAD_T    mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        full;
	logic        do_wr;
	logic        do_rd;

	// Extra pointer bit tells full from empty
	assign empty_o = (wr_ptr == rd_ptr);
	assign full    = (wr_ptr[AW] != rd_ptr[AW]) &&
	                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_wr = wr_i & ~full;      // Full drops the word
	assign do_rd = rd_i & ~empty_o;

	////////////////////////////////////////////////////////////////////////////
	// Pointers and overflow flag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			ovf_o  <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_i && full) begin
				ovf_o <= 1'b1;          // Sticky until reset
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Storage with the output registered on read
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge WRCLK) begin
		if (do_wr) begin
			mem[wr_ptr[AW-1:0]] <= din_i;
		end
		if (do_rd) begin
			dout_o <= mem[rd_ptr[AW-1:0]];
		end
	end

	// Reading an empty FIFO would wrap the fill level past the depth
	a_no_read_empty: assert property (
		@(posedge WRCLK) disable iff (RST_RESYNC)
		(AW+1)'(wr_ptr - rd_ptr) <= (AW+1)'(DEPTH)
	) else $error("fill level out of range");

endmodule

//--- hdl/group_mux.sv
`timescale 1ns/1ps
`include "fifo16_cfg.svh"

module group_mux (
	input  logic                 WRCLK,
	input  logic                 RST_RESYNC,
	input  sample_pkg::grp_bus_t grp_i [`FIFO16_NUM_GRP],
	input  sample_pkg::grp_sel_t grp_sel_i,
	input  logic                 wr_i,
	output sample_pkg::grp_bus_t ch_data_o,
	output logic                 ch_wr_o
);

	sample_pkg::grp_bus_t sel_bus;

	// Unused select codes give zero
	always_comb begin
		sel_bus = '0;
		for (int g = 0; g < `FIFO16_NUM_GRP; g++) begin
			if (grp_sel_i == sample_pkg::grp_sel_t'(g)) begin
				sel_bus = grp_i[g];
			end
		end
	end

	// Word per channel lined up with the delayed strobe
	always_ff @(posedge WRCLK) begin
		for (int ch = 0; ch < `FIFO16_NUM_CH; ch++) begin
			ch_data_o[ch] <= sel_bus[ch];
		end
	end

	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			ch_wr_o <= 1'b0;
		end else begin
			ch_wr_o <= wr_i;
		end
	end

endmodule

//--- hdl/load_sequencer.sv
`timescale 1ns/1ps
`include "fifo16_cfg.svh"

module load_sequencer (
	input  logic                  WRCLK,
	input  logic                  RST_RESYNC,
	input  logic                  evt_start_i,
	input  sample_pkg::smp_cnt_t  samp_max_i,
	output sample_pkg::grp_sel_t  grp_sel_o,
	output logic                  wr_o,
	output logic                  busy_o
);

	logic                 run;
	sample_pkg::grp_sel_t grp_cnt;
	sample_pkg::smp_cnt_t smp_cnt;
	sample_pkg::smp_cnt_t smp_max_q;
	logic                 grp_last;
	logic                 smp_last;

	assign grp_last = (grp_cnt == sample_pkg::grp_sel_t'(`FIFO16_NUM_GRP - 1));
	assign smp_last = (smp_cnt == smp_max_q);

	////////////////////////////////////////////////////////////////////////////
	// Write burst of one group per clock over SAMP_MAX+1 passes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			run       <= 1'b0;
			grp_cnt   <= '0;
			smp_cnt   <= '0;
			smp_max_q <= '0;
		end else if (!run) begin
			grp_cnt <= '0;
			smp_cnt <= '0;
			if (evt_start_i) begin
				run       <= 1'b1;
				smp_max_q <= samp_max_i;   // Held for the whole event
			end
		end else if (grp_last) begin
			grp_cnt <= '0;
			if (smp_last) begin
				run <= 1'b0;            // Last write of the event
			end else begin
				smp_cnt <= smp_cnt + 1'b1;
			end
		end else begin
			grp_cnt <= grp_cnt + 1'b1;
		end
	end

	assign grp_sel_o = grp_cnt;
	assign wr_o      = run;
	assign busy_o    = run;

	a_grp_in_range: assert property (
		@(posedge WRCLK) disable iff (RST_RESYNC)
		wr_o |-> (grp_sel_o < sample_pkg::grp_sel_t'(`FIFO16_NUM_GRP))
	) else $error("group select out of range during write");

endmodule

//--- hdl/trig_counter.sv
`timescale 1ns/1ps

module trig_counter (
	input  logic                  WRCLK,
	input  logic                  RST_RESYNC,
	input  logic                  l1a_i,
	input  logic                  l1a_match_i,
	input  logic                  busy_i,
	output logic                  evt_start_o,
	output trigger_pkg::evt_hdr_t hdr_o
);

	trigger_pkg::l1a_cnt_t  l1a_cnt;
	trigger_pkg::mtch_cnt_t mtch_cnt;
	trigger_pkg::l1a_cnt_t  l1a_cnt_nxt;
	trigger_pkg::mtch_cnt_t mtch_cnt_nxt;
	logic                   start;

	assign l1a_cnt_nxt  = l1a_i ? l1a_cnt + 1'b1 : l1a_cnt;
	assign mtch_cnt_nxt = l1a_match_i ? mtch_cnt + 1'b1 : mtch_cnt;

	// Busy from the sequencer rises one cycle after our pulse,
	// so our own pulse covers that gap
	assign start = l1a_match_i & ~busy_i & ~evt_start_o;

	////////////////////////////////////////////////////////////////////////////
	// Counters and start pulse
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge WRCLK) begin
		if (RST_RESYNC) begin
			l1a_cnt     <= '0;
			mtch_cnt    <= '0;
			evt_start_o <= 1'b0;
		end else begin
			l1a_cnt     <= l1a_cnt_nxt;
			mtch_cnt    <= mtch_cnt_nxt;   // Counted even while loading
			evt_start_o <= start;
		end
	end

	// Header includes the strobes of the start edge itself
	always_ff @(posedge WRCLK) begin
		if (start) begin
			hdr_o.l1a_cnt  <= l1a_cnt_nxt;
			hdr_o.mtch_cnt <= mtch_cnt_nxt;
		end
	end

	// Only one event may be loading at a time
	a_start_not_busy: assert property (
		@(posedge WRCLK) disable iff (RST_RESYNC)
		evt_start_o |-> !busy_i
	) else $error("event start while sequencer busy");

endmodule

//--- hdl/trigger_pkg.sv
`include "fifo16_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// Trigger bookkeeping and the per-event header
////////////////////////////////////////////////////////////////////////////

package trigger_pkg;

	// Running count of L1A strobes
	typedef logic [`FIFO16_L1A_W-1:0] l1a_cnt_t;

	// Running count of L1A_MATCH strobes
	typedef logic [`FIFO16_MTCH_W-1:0] mtch_cnt_t;

	// Counts captured on the edge that starts the event
	// L1A count sits in the upper bits when read as a flat word
	typedef struct packed {
		l1a_cnt_t  l1a_cnt;
		mtch_cnt_t mtch_cnt;
	} evt_hdr_t;

endpackage

//--- hdl/sample_pkg.sv
`include "fifo16_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// Sample data as it arrives from the front end
////////////////////////////////////////////////////////////////////////////

package sample_pkg;

	// One digitised word of a single channel
	typedef logic [`FIFO16_SMP_W-1:0] smp_word_t;

	// Index of the group bus being loaded
	typedef logic [2:0] grp_sel_t;

	// All channel words of one group, channel 0 in the low bits
	typedef smp_word_t [`FIFO16_NUM_CH-1:0] grp_bus_t;

	// Sample index within an event, same width as SAMP_MAX
	typedef logic [`FIFO16_SMPMAX_W-1:0] smp_cnt_t;

endpackage

//--- include/fifo16_cfg.svh
`ifndef FIFO16_CFG_SVH
`define FIFO16_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Channel and group geometry
////////////////////////////////////////////////////////////////////////////

`define FIFO16_NUM_CH     16     // Channels per group bus
`define FIFO16_NUM_GRP    6      // Group buses per sample
`define FIFO16_SMP_W      12     // Channel word
`define FIFO16_SMPMAX_W   3      // Up to 8 samples per event

////////////////////////////////////////////////////////////////////////////
// Buffer depths
////////////////////////////////////////////////////////////////////////////

`define FIFO16_CH_DEPTH   64     // Words per channel FIFO
`define FIFO16_HDR_DEPTH  4      // Pending event headers

////////////////////////////////////////////////////////////////////////////
// Trigger counters
////////////////////////////////////////////////////////////////////////////

`define FIFO16_L1A_W      24
`define FIFO16_MTCH_W     12

`endif
